//--- hw/md_pkg.sv
// shared widths, Wishbone word map and stage structs; coordinates are signed 10-bit and N is at most 32
package md_pkg;
	localparam int COORD_W     = 10;             // signed coordinate
	localparam int DELTA_W     = 11;             // signed displacement
	localparam int R2_W        = 22;             // unsigned r squared
	localparam int MAX_PART    = 32;
	localparam int PART_IDX_W  = 5;
	localparam int NPART_W     = PART_IDX_W + 1; // holds 0..32
	localparam int CUTOFF_2    = 4096;           // r2 at or above this is dropped
	localparam int BIN_SHIFT   = 6;              // low r2 bits form the fraction
	localparam int BIN_NUM     = 64;
	localparam int BIN_W       = 6;
	localparam int COEF_W      = 16;
	localparam int COEF_INT_W  = COEF_W + 2;     // interpolated coefficient
	localparam int FORCE_W     = 32;
	localparam int RES_DEPTH   = 64;
	localparam int RES_ADDR_W  = 6;
	localparam int RES_CNT_W   = RES_ADDR_W + 1; // count saturates at RES_DEPTH
	localparam int RES_RADDR_W = RES_ADDR_W + 2; // four words per result

	// host port, word addressed
	localparam int WB_ADR_W = 11;
	localparam int WB_DAT_W = 32;
	localparam logic [WB_ADR_W-1:0] REG_CTRL   = 'h000;
	localparam logic [WB_ADR_W-1:0] REG_STATUS = 'h001;
	localparam logic [WB_ADR_W-1:0] REG_NPART  = 'h002;
	localparam logic [WB_ADR_W-1:0] POS_BASE   = 'h100;
	localparam logic [WB_ADR_W-1:0] COEF_BASE  = 'h200;
	localparam logic [WB_ADR_W-1:0] RES_BASE   = 'h400;

	typedef enum logic [2:0] {
		SEL_CTRL,
		SEL_STATUS,
		SEL_NPART,
		SEL_POS,
		SEL_COEF,
		SEL_RES,
		SEL_NONE
	} wb_sel_e;

	typedef enum logic {IDLE, RUN} pair_gen_state_e;

	// z on top so the struct lines up with the host word (x in 9:0)
	typedef struct packed {
		logic signed [COORD_W-1:0] z;
		logic signed [COORD_W-1:0] y;
		logic signed [COORD_W-1:0] x;
	} pos_t;

	typedef struct packed {
		logic signed [COEF_W-1:0] c1; // slope, bits 31:16
		logic signed [COEF_W-1:0] c0; // base, bits 15:0
	} coef_t;

	typedef struct packed {
		logic                  valid;
		logic                  last;
		logic [PART_IDX_W-1:0] idx_i;
		logic [PART_IDX_W-1:0] idx_j;
		pos_t                  pos_i;
		pos_t                  pos_j;
	} pair_t;

	typedef struct packed {
		logic                      valid;
		logic                      last;
		logic [PART_IDX_W-1:0]     idx_i;
		logic [PART_IDX_W-1:0]     idx_j;
		logic signed [DELTA_W-1:0] dx;
		logic signed [DELTA_W-1:0] dy;
		logic signed [DELTA_W-1:0] dz;
		logic [R2_W-1:0]           r2;
	} dist_t;

	typedef struct packed {
		logic                      valid;
		logic                      last;
		logic [PART_IDX_W-1:0]     idx_i;
		logic [PART_IDX_W-1:0]     idx_j;
		logic signed [FORCE_W-1:0] fx;
		logic signed [FORCE_W-1:0] fy;
		logic signed [FORCE_W-1:0] fz;
	} force_t;
endpackage

//--- hw/md_wb_regs.sv
// Wishbone classic slave, ack two cycles after stb; the master must hold cyc/stb until ack
`timescale 1ns/1ps

module md_wb_regs
	import md_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic [WB_ADR_W-1:0]    wb_adr,
	input  logic [WB_DAT_W-1:0]    wb_dat_w,
	input  logic                   done_pulse,
	input  logic [RES_CNT_W-1:0]   res_count,
	input  logic                   overflow,
	input  coef_t                  coef_rdata,
	input  logic [FORCE_W-1:0]     res_rdata,
	output logic                   wb_ack,
	output logic [WB_DAT_W-1:0]    wb_dat_r,
	output logic                   start,
	output logic [NPART_W-1:0]     npart,
	output logic                   pos_we,
	output logic [PART_IDX_W-1:0]  pos_waddr,
	output pos_t                   pos_wdata,
	output logic                   coef_we,
	output logic [BIN_W-1:0]       coef_addr,
	output coef_t                  coef_wdata,
	output logic [RES_RADDR_W-1:0] res_raddr
);
	wb_sel_e sel;                 // decoded target of the current access
	logic pend;                   // request seen, RAM read in progress
	logic busy;
	logic done;
	logic wr_ok;                  // write slot, only while idle
	logic [WB_DAT_W-1:0] status_word;

	// address decode, regions matched on their upper bits
	always_comb
	begin
		if (wb_adr == REG_CTRL)
			sel = SEL_CTRL;
		else if (wb_adr == REG_STATUS)
			sel = SEL_STATUS;
		else if (wb_adr == REG_NPART)
			sel = SEL_NPART;
		else if (wb_adr[WB_ADR_W-1:PART_IDX_W] == POS_BASE[WB_ADR_W-1:PART_IDX_W])
			sel = SEL_POS;
		else if (wb_adr[WB_ADR_W-1:BIN_W] == COEF_BASE[WB_ADR_W-1:BIN_W])
			sel = SEL_COEF;
		else if (wb_adr[WB_ADR_W-1:RES_RADDR_W] == RES_BASE[WB_ADR_W-1:RES_RADDR_W])
			sel = SEL_RES;
		else
			sel = SEL_NONE;
	end

	// writes land in the pend cycle, adr and data are stable by then
	assign wr_ok = pend & wb_we & ~busy;
	assign start = wr_ok & (sel == SEL_CTRL) & wb_dat_w[0]; // start while busy is dropped

	assign pos_we    = wr_ok & (sel == SEL_POS);
	assign pos_waddr = wb_adr[PART_IDX_W-1:0];
	assign pos_wdata = pos_t'(wb_dat_w[3*COORD_W-1:0]);

	assign coef_we    = wr_ok & (sel == SEL_COEF);
	assign coef_addr  = wb_adr[BIN_W-1:0];   // shared by write and read-back
	assign coef_wdata = coef_t'(wb_dat_w);
	assign res_raddr  = wb_adr[RES_RADDR_W-1:0];

	always_comb
	begin
		status_word = '0;
		status_word[0] = busy;
		status_word[1] = done;
		status_word[2] = overflow;
		status_word[16 +: RES_CNT_W] = res_count;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pend   <= 1'b0;
			wb_ack <= 1'b0;
			busy   <= 1'b0;
			done   <= 1'b0;
			npart  <= '0;
		end
		else
		begin
			pend   <= wb_cyc & wb_stb & ~pend & ~wb_ack; // one request per stb
			wb_ack <= pend;
			if (start)
			begin
				busy <= 1'b1;
				done <= 1'b0;
			end
			else if (done_pulse)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (wr_ok && sel == SEL_NPART)
				npart <= (wb_dat_w > MAX_PART) ? NPART_W'(MAX_PART) : wb_dat_w[NPART_W-1:0];
		end
	end

	// read mux; RAM outputs were registered in the cycle with stb
	always_ff @(posedge clk)
	begin
		if (pend)
		begin
			case (sel)
				SEL_STATUS: wb_dat_r <= status_word;
				SEL_NPART:  wb_dat_r <= WB_DAT_W'(npart);
				SEL_COEF:   wb_dat_r <= coef_rdata;
				SEL_RES:    wb_dat_r <= res_rdata;
				default:    wb_dat_r <= '0;        // ctrl and positions are write only
			endcase
		end
	end
endmodule

//--- hw/md_pair_gen.sv
// ordered pair sequencer over positions 0..N-1, one pair per clock; N below 2 gives one bubble
`timescale 1ns/1ps

module md_pair_gen
	import md_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  logic [NPART_W-1:0]    npart,
	input  logic                  pos_we,
	input  logic [PART_IDX_W-1:0] pos_waddr,
	input  pos_t                  pos_wdata,
	output pair_t                 pair_out
);
	pair_gen_state_e state;
	logic [PART_IDX_W-1:0] idx_i;
	logic [PART_IDX_W-1:0] idx_j;
	logic [NPART_W-1:0] j_next1;  // j + 1
	logic [NPART_W-1:0] j_step;   // next j, skipping i
	logic few;                    // no pairs to form
	logic issue_valid;
	logic issue_last;
	pos_t pos_mem [MAX_PART];

	assign few = npart < NPART_W'(2);
	assign j_next1 = NPART_W'(idx_j) + NPART_W'(1);
	assign j_step = (j_next1 == NPART_W'(idx_i)) ? j_next1 + NPART_W'(1) : j_next1;

	assign issue_valid = (state == RUN) && !few;
	// final ordered pair is (N-1, N-2)
	assign issue_last = (state == RUN) && (few ||
		(NPART_W'(idx_i) == npart - NPART_W'(1) && NPART_W'(idx_j) == npart - NPART_W'(2)));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			idx_i <= '0;
			idx_j <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state <= RUN;
						idx_i <= '0;
						idx_j <= PART_IDX_W'(1); // (0,0) is skipped
					end
				end
				RUN:
				begin
					if (issue_last)
						state <= IDLE;
					else if (j_step >= npart)
					begin
						idx_i <= idx_i + PART_IDX_W'(1);
						idx_j <= '0;                  // i is at least 1 here
					end
					else
						idx_j <= j_step[PART_IDX_W-1:0];
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (pos_we)
			pos_mem[pos_waddr] <= pos_wdata;
	end

	// two read ports, one per side of the pair
	always_ff @(posedge clk)
	begin
		pair_out.idx_i <= idx_i;
		pair_out.idx_j <= idx_j;
		pair_out.pos_i <= pos_mem[idx_i];
		pair_out.pos_j <= pos_mem[idx_j];
		if (rst)
		begin
			pair_out.valid <= 1'b0;
			pair_out.last  <= 1'b0;
		end
		else
		begin
			pair_out.valid <= issue_valid;
			pair_out.last  <= issue_last;
		end
	end
endmodule

//--- hw/md_dist_stage.sv
// displacement then r2 and cutoff, two register stages; filtered pairs keep their last bit
`timescale 1ns/1ps

module md_dist_stage
	import md_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  pair_t pair_in,
	output dist_t dist_out
);
	dist_t s1;                     // displacements, r2 still empty
	logic signed [2*DELTA_W-1:0] sq_x;
	logic signed [2*DELTA_W-1:0] sq_y;
	logic signed [2*DELTA_W-1:0] sq_z;
	logic [R2_W-1:0] r2_sum;

	// stage 1: operands sign-extend to DELTA_W, no overflow
	always_ff @(posedge clk)
	begin
		s1.idx_i <= pair_in.idx_i;
		s1.idx_j <= pair_in.idx_j;
		s1.dx    <= pair_in.pos_i.x - pair_in.pos_j.x;
		s1.dy    <= pair_in.pos_i.y - pair_in.pos_j.y;
		s1.dz    <= pair_in.pos_i.z - pair_in.pos_j.z;
		s1.r2    <= '0;              // filled in stage 2
		if (rst)
		begin
			s1.valid <= 1'b0;
			s1.last  <= 1'b0;
		end
		else
		begin
			s1.valid <= pair_in.valid;
			s1.last  <= pair_in.last;
		end
	end

	assign sq_x = s1.dx * s1.dx;
	assign sq_y = s1.dy * s1.dy;
	assign sq_z = s1.dz * s1.dz;
	assign r2_sum = $unsigned(sq_x) + $unsigned(sq_y) + $unsigned(sq_z); // squares are >= 0

	// stage 2: r2 plus the cutoff filter
	always_ff @(posedge clk)
	begin
		dist_out <= s1;
		dist_out.r2 <= r2_sum;
		if (rst)
		begin
			dist_out.valid <= 1'b0;
			dist_out.last  <= 1'b0;
		end
		else
			dist_out.valid <= s1.valid && (r2_sum < CUTOFF_2);
	end
endmodule

//--- hw/md_force_stage.sv
// table lookup, first-order interpolation and force multiply, three stages; bins past 63 wrap
`timescale 1ns/1ps

module md_force_stage
	import md_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  dist_t            dist_in,
	input  logic             coef_we,
	input  logic [BIN_W-1:0] coef_addr,
	input  coef_t            coef_wdata,
	output coef_t            coef_rdata,
	output force_t           force_out
);
	coef_t coef_mem [BIN_NUM];
	dist_t sa;                          // after the table read
	dist_t sb;                          // after the interpolation
	coef_t coef_pipe;                   // table word for sa
	logic [BIN_W-1:0] bin;
	logic [BIN_SHIFT-1:0] frac;
	logic signed [COEF_W+BIN_SHIFT:0] slope; // c1 * frac, full width
	logic signed [COEF_INT_W-1:0] coef_a;
	logic signed [COEF_INT_W-1:0] coef_b;

	// only kept pairs matter, they have r2 below 4096 so the bin fits
	assign bin = dist_in.r2[BIN_SHIFT +: BIN_W];

	// host port, also used for read-back
	always_ff @(posedge clk)
	begin
		if (coef_we)
			coef_mem[coef_addr] <= coef_wdata;
		coef_rdata <= coef_mem[coef_addr];
	end

	// stage A: pipeline read port
	always_ff @(posedge clk)
	begin
		sa <= dist_in;
		coef_pipe <= coef_mem[bin];
		if (rst)
		begin
			sa.valid <= 1'b0;
			sa.last  <= 1'b0;
		end
	end

	assign frac = sa.r2[BIN_SHIFT-1:0];
	assign slope = coef_pipe.c1 * $signed({1'b0, frac});     // frac is unsigned
	assign coef_a = COEF_INT_W'(coef_pipe.c0) + COEF_INT_W'(slope >>> BIN_SHIFT);

	// stage B: interpolated coefficient
	always_ff @(posedge clk)
	begin
		sb <= sa;
		coef_b <= coef_a;
		if (rst)
		begin
			sb.valid <= 1'b0;
			sb.last  <= 1'b0;
		end
	end

	// stage C: products sign-extend into the 32-bit fields
	always_ff @(posedge clk)
	begin
		force_out.idx_i <= sb.idx_i;
		force_out.idx_j <= sb.idx_j;
		force_out.fx <= coef_b * sb.dx;
		force_out.fy <= coef_b * sb.dy;
		force_out.fz <= coef_b * sb.dz;
		if (rst)
		begin
			force_out.valid <= 1'b0;
			force_out.last  <= 1'b0;
		end
		else
		begin
			force_out.valid <= sb.valid;
			force_out.last  <= sb.last;
		end
	end
endmodule

//--- hw/md_result_store.sv
// results RAM, four words per pair; keeps the first 64 results of a run and flags the rest
`timescale 1ns/1ps

module md_result_store
	import md_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  force_t                 force_in,
	input  logic [RES_RADDR_W-1:0] res_raddr,
	output logic [FORCE_W-1:0]     res_rdata,
	output logic [RES_CNT_W-1:0]   res_count,
	output logic                   overflow,
	output logic                   done_pulse
);
	logic [3:0][FORCE_W-1:0] res_mem [RES_DEPTH]; // word 0 fx .. word 3 pair
	logic [FORCE_W-1:0] pair_word;
	logic room;

	assign room = res_count < RES_CNT_W'(RES_DEPTH);
	assign pair_word = FORCE_W'({force_in.idx_i, 3'b000, force_in.idx_j}); // i in 12:8

	always_ff @(posedge clk)
	begin
		if (force_in.valid && room)
			res_mem[res_count[RES_ADDR_W-1:0]] <= {pair_word, force_in.fz, force_in.fy, force_in.fx};
		res_rdata <= res_mem[res_raddr[RES_RADDR_W-1:2]][res_raddr[1:0]];
	end

	always_ff @(posedge clk)
	begin
		if (rst || start)
		begin
			res_count  <= '0;
			overflow   <= 1'b0;
			done_pulse <= 1'b0;
		end
		else
		begin
			done_pulse <= force_in.last;  // also carried by filtered items
			if (force_in.valid)
			begin
				if (room)
					res_count <= res_count + RES_CNT_W'(1);
				else
					overflow <= 1'b1;        // result dropped
			end
		end
	end
endmodule

//--- hw/md_force_top.sv
// force engine top, single clock; host access only through the Wishbone port
`timescale 1ns/1ps

module md_force_top
	import md_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  logic [WB_ADR_W-1:0] wb_adr,
	input  logic [WB_DAT_W-1:0] wb_dat_w,
	output logic                wb_ack,
	output logic [WB_DAT_W-1:0] wb_dat_r
);
	logic start;
	logic [NPART_W-1:0] npart;
	logic pos_we;
	logic [PART_IDX_W-1:0] pos_waddr;
	pos_t pos_wdata;
	logic coef_we;
	logic [BIN_W-1:0] coef_addr;
	coef_t coef_wdata;
	coef_t coef_rdata;
	logic [RES_RADDR_W-1:0] res_raddr;
	logic [FORCE_W-1:0] res_rdata;
	logic [RES_CNT_W-1:0] res_count;
	logic overflow;
	logic done_pulse;
	pair_t pair_s;   // pair_gen -> dist
	dist_t dist_s;   // dist -> force
	force_t force_s; // force -> store

	md_wb_regs u_regs (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
		.done_pulse(done_pulse), .res_count(res_count), .overflow(overflow),
		.coef_rdata(coef_rdata), .res_rdata(res_rdata),
		.start(start), .npart(npart),
		.pos_we(pos_we), .pos_waddr(pos_waddr), .pos_wdata(pos_wdata),
		.coef_we(coef_we), .coef_addr(coef_addr), .coef_wdata(coef_wdata),
		.res_raddr(res_raddr)
	);

	md_pair_gen u_pair_gen (
		.clk(clk), .rst(rst), .start(start), .npart(npart),
		.pos_we(pos_we), .pos_waddr(pos_waddr), .pos_wdata(pos_wdata),
		.pair_out(pair_s)
	);

	md_dist_stage u_dist (.clk(clk), .rst(rst), .pair_in(pair_s), .dist_out(dist_s));

	md_force_stage u_force (
		.clk(clk), .rst(rst), .dist_in(dist_s),
		.coef_we(coef_we), .coef_addr(coef_addr), .coef_wdata(coef_wdata),
		.coef_rdata(coef_rdata), .force_out(force_s)
	);

	md_result_store u_store (
		.clk(clk), .rst(rst), .start(start), .force_in(force_s),
		.res_raddr(res_raddr), .res_rdata(res_rdata),
		.res_count(res_count), .overflow(overflow), .done_pulse(done_pulse)
	);
endmodule

//--- verification/md_force_sva.sv
// host handshake and cutoff checks bound into md_force_top; reaches into u_regs for busy
`timescale 1ns/1ps

module md_force_sva
	import md_pkg::*;
(
	input logic   clk,
	input logic   rst,
	input logic   wb_cyc,
	input logic   wb_stb,
	input logic   wb_ack,
	input logic   busy,
	input dist_t  dist_s,
	input force_t force_s
);
	int fail_count = 0; // failed assertions so far

	// ack only inside a request and for one clock
	ack_in_request: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_cyc && wb_stb)
	else
	begin
		$error("ack outside cyc and stb");
		fail_count++;
	end
	ack_one_clock: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
	else
	begin
		$error("ack held longer than one clock");
		fail_count++;
	end
	// three force stages sit between the filter and the result
	cutoff_drops: assert property (@(posedge clk) disable iff (rst)
		dist_s.r2 >= R2_W'(CUTOFF_2) |-> ##3 !force_s.valid)
	else
	begin
		$error("valid force from a pair at or beyond the cutoff");
		fail_count++;
	end
	idle_after_reset: assert property (@(posedge clk) rst |=> !busy)
	else
	begin
		$error("busy set right after reset");
		fail_count++;
	end
endmodule

bind md_force_top md_force_sva sva0 (
	.clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
	.busy(u_regs.busy), .dist_s(dist_s), .force_s(force_s)
);

//--- verification/md_force_tb.sv
// self-checking; run from the project root for verification/md_stimulus.txt, N at most 32
`timescale 1ns/1ps

module md_force_tb
	import md_pkg::*;
();
	localparam int CLK_PERIOD = 40;
	localparam int STIM_WORDS = 512;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [WB_ADR_W-1:0] wb_adr;
	logic [WB_DAT_W-1:0] wb_dat_w;
	logic wb_ack;
	logic [WB_DAT_W-1:0] wb_dat_r;

	logic [31:0] stim [STIM_WORDS];    // hex words of the stimulus file
	logic [31:0] coef_word [BIN_NUM];  // own copy of the table
	int px [MAX_PART];
	int py [MAX_PART];
	int pz [MAX_PART];
	int exp_fx [$];                    // kept pairs in issue order
	int exp_fy [$];
	int exp_fz [$];
	int exp_pair [$];
	int seed;
	int errors;
	int test_errors;                   // error count at the start of the current test
	int tests_run;
	int tests_failed;
	int wd_cycles;

	md_force_top dut0 (
		.clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %s got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("error: %s", what);
		errors++;
	endtask

	// one classic cycle, ack expected on the second clock after stb
	task automatic bus_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waits;
		waits = 0;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdata;
		@(negedge clk);                // outputs sampled mid-cycle
		while (!wb_ack)
		begin
			@(negedge clk);
			waits++;
		end
		rdata = wb_dat_r;
		if (waits != 2)
			report_problem($sformatf("ack came %0d cycles after stb at address %h", waits, adr));
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(negedge clk);
		if (wb_ack)
			report_problem($sformatf("ack stayed high a second cycle at address %h", adr));
	endtask

	task automatic write_word(input logic [WB_ADR_W-1:0] adr, input logic [31:0] wdata);
		logic [31:0] dummy;
		bus_cycle(1'b1, adr, wdata, dummy);
	endtask

	task automatic read_word(input logic [WB_ADR_W-1:0] adr, output logic [31:0] rdata);
		bus_cycle(1'b0, adr, 32'h0, rdata);
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (errors == test_errors)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	function automatic int coord_of(input logic [31:0] w);
		logic signed [COORD_W-1:0] c;
		c = w[COORD_W-1:0];
		return c;                      // sign extends
	endfunction

	function automatic logic [31:0] pos_word(input int k);
		return {2'b00, COORD_W'(pz[k]), COORD_W'(py[k]), COORD_W'(px[k])};
	endfunction

	// every ordered pair i != j, cutoff, table lookup with linear step, force per axis
	task automatic build_model(input int n, output int kept);
		int i;
		int j;
		int dx;
		int dy;
		int dz;
		int r2;
		int c0;
		int c1;
		int coef;
		logic [31:0] w;
		kept = 0;
		exp_fx.delete();
		exp_fy.delete();
		exp_fz.delete();
		exp_pair.delete();
		for (i = 0; i < n; i++)
			for (j = 0; j < n; j++)
				if (i != j)
				begin
					dx = px[i] - px[j];
					dy = py[i] - py[j];
					dz = pz[i] - pz[j];
					r2 = dx * dx + dy * dy + dz * dz;
					if (r2 < CUTOFF_2)
					begin
						w = coef_word[r2 >> BIN_SHIFT];
						c0 = $signed(w[15:0]);
						c1 = $signed(w[31:16]);
						coef = c0 + ((c1 * (r2 & ((1 << BIN_SHIFT) - 1))) >>> BIN_SHIFT);
						exp_fx.push_back(coef * dx);
						exp_fy.push_back(coef * dy);
						exp_fz.push_back(coef * dz);
						exp_pair.push_back((i << 8) | j);
						kept++;
					end
				end
	endtask

	// ends a hung run, limit derived from the run sizes
	initial
	begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", wd_cycles);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin : main
		logic [31:0] rd;
		logic [31:0] exp_status;
		logic [31:0] exp_word [4];
		string word_name [4];
		int ptr;
		int n;
		int k;
		int w;
		int kept;
		int file_kept;
		int stored;
		int run;

		rst      = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		seed = 32'h9f4a_c698;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		word_name[0] = "fx";
		word_name[1] = "fy";
		word_name[2] = "fz";
		word_name[3] = "pair";
		for (k = 0; k < STIM_WORDS; k++)
			stim[k] = '0;                // zero marks the end of the list
		$readmemh("verification/md_stimulus.txt", stim);

		// status, table write and read-back, npart write and read
		wd_cycles = 3 * (1 + 2 * BIN_NUM + 2);
		ptr = 0;
		while (stim[ptr] != 0 && stim[ptr] <= MAX_PART)
		begin
			n = stim[ptr];
			file_kept = stim[ptr + 1];
			stored = (file_kept > RES_DEPTH) ? RES_DEPTH : file_kept;
			wd_cycles += n * n + 20 + 3 * (n + 6 + 4 * stored);
			ptr += 2 + 3 * n;
		end
		wd_cycles = 2 * wd_cycles;

		repeat (5) @(posedge clk);
		rst <= 1'b0;
		if (stim[0] == 0)
			report_problem("stimulus file is missing or holds no run");

		read_word(REG_STATUS, rd);
		if (rd !== 32'h0)
			report_mismatch("wb_dat_r (status after reset)", rd, 32'h0);
		close_test("reset_status");

		for (k = 0; k < BIN_NUM; k++)
		begin
			coef_word[k] = $random(seed);
			write_word(COEF_BASE + WB_ADR_W'(k), coef_word[k]);
		end
		for (k = 0; k < BIN_NUM; k++)
		begin
			read_word(COEF_BASE + WB_ADR_W'(k), rd);
			if (rd !== coef_word[k])
				report_mismatch($sformatf("coef[%0d]", k), rd, coef_word[k]);
		end
		write_word(REG_NPART, 32'd5);
		read_word(REG_NPART, rd);
		if (rd !== 32'd5)
			report_mismatch("wb_dat_r (npart)", rd, 32'd5);
		close_test("table_readback");

		ptr = 0;
		run = 0;
		while (stim[ptr] != 0 && stim[ptr] <= MAX_PART)
		begin
			n = stim[ptr];
			file_kept = stim[ptr + 1];
			ptr += 2;
			for (k = 0; k < n; k++)
			begin
				px[k] = coord_of(stim[ptr]);
				py[k] = coord_of(stim[ptr + 1]);
				pz[k] = coord_of(stim[ptr + 2]);
				ptr += 3;
			end
			build_model(n, kept);
			if (kept != file_kept)
				report_mismatch("kept count (file, model)", file_kept, kept);
			write_word(REG_NPART, n);
			for (k = 0; k < n; k++)
				write_word(POS_BASE + WB_ADR_W'(k), pos_word(k));
			write_word(REG_CTRL, 32'h1);
			// long runs only, these land while the engine works
			if (n >= 5)
			begin
				write_word(POS_BASE, pos_word(0) ^ 32'h1555_5555);
				write_word(REG_CTRL, 32'h1);
				read_word(REG_STATUS, rd);
				if (!rd[0])
					report_problem("engine was not busy during the ignored writes");
			end
			rd = '0;
			while (!rd[1])
				read_word(REG_STATUS, rd);   // wait for done
			stored = (kept > RES_DEPTH) ? RES_DEPTH : kept;
			exp_status = (stored << 16) | ((kept > RES_DEPTH) ? 32'h4 : 32'h0) | 32'h2;
			if (rd !== exp_status)
				report_mismatch("wb_dat_r (status after run)", rd, exp_status);
			for (k = 0; k < stored; k++)
			begin
				exp_word[0] = exp_fx[k];
				exp_word[1] = exp_fy[k];
				exp_word[2] = exp_fz[k];
				exp_word[3] = exp_pair[k];
				for (w = 0; w < 4; w++)
				begin
					read_word(RES_BASE + WB_ADR_W'(4 * k + w), rd);
					if (rd !== exp_word[w])
						report_mismatch($sformatf("%s[%0d]", word_name[w], k), rd, exp_word[w]);
				end
			end
			close_test($sformatf("run%0d_n%0d", run, n));
			run++;
		end

		// protocol and cutoff properties from the bound checker
		if (dut0.sva0.fail_count != 0)
			report_problem($sformatf("%0d assertion failures in the bound checker",
				dut0.sva0.fail_count));
		close_test("assertions");

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end
endmodule

//--- verification/md_stimulus.txt
// hex words; run line is N then the expected kept-pair count, then N lines of x y z
// coordinates are 10-bit two's complement; a run line of 0 0 ends the list
1 0
010 3f6 001
4 8
000 000 000
00a 3fb 003
040 000 000
3ec 01e 3f6
6 14
005 005 005
3fb 007 000
014 3f6 00f
0c8 0c8 0c8
000 3e2 3ec
028 00a 3fb
9 48
000 000 000
003 001 002
3fc 002 001
005 3fd 000
001 006 3fe
3fe 3fb 004
007 002 3fa
3fa 003 005
002 3f9 3fd
0 0

//--- tb.f
hw/md_pkg.sv
hw/md_wb_regs.sv
hw/md_pair_gen.sv
hw/md_dist_stage.sv
hw/md_force_stage.sv
hw/md_result_store.sv
hw/md_force_top.sv
verification/md_force_sva.sv
verification/md_force_tb.sv
